// File: source/sar_adc_pkg.sv
// Shared widths, register map, bus structs and FSM states for the SAR ADC controller RTL
package sar_adc_pkg;

  // Plain vector types
  typedef logic [31:0] reg_data_t;   // Bus data word
  typedef logic [3:0]  reg_addr_t;   // Word address
  typedef logic [3:0]  reg_be_t;     // One enable per byte lane
  typedef logic [7:0]  dac_code_t;   // DAC code and conversion result
  typedef logic [3:0]  sar_timer_t;  // Timer load value

  localparam reg_addr_t TIMING_ADDR = 4'd4;  // Shared timing register
  localparam int        SAR_BITS    = 8;     // Binary search depth

  // ------------------------------------------------------------
  // Channel register bit positions
  localparam int CH_DAC_SEL_BIT  = 0;
  localparam int CH_SAR_EN_BIT   = 1;
  localparam int CH_MAN_TRG_BIT  = 2;
  localparam int CH_MAN_CODE_LSB = 8;   // Bits 15 to 8
  localparam int CH_RESULT_LSB   = 16;  // Bits 23 to 16, read only
  localparam int CH_CMP_BIT      = 30;  // Conditioned comparator, read only
  localparam int CH_REQ_BIT      = 31;  // Self clearing sample request

  // Timing register bit positions
  localparam int TM_SH_LSB  = 0;
  localparam int TM_DAC_LSB = 4;
  localparam int TM_CMP_LSB = 8;
  localparam int TM_INV_BIT = 12;

  // ------------------------------------------------------------
  typedef struct packed {
    logic      adc_dac_sel;
    logic      sar_enable;
    logic      man_sample;    // Manual sample trigger
    dac_code_t man_dac_code;
    logic      sample_req;    // Starts the engine
  } ch_cfg_t;

  typedef struct packed {
    sar_timer_t sh_timer;     // Sample hold
    sar_timer_t dac_timer;    // DAC settle
    sar_timer_t comp_timer;   // Comparator wait
    logic       invert_cmp;
  } sar_timing_t;

  typedef struct packed {
    logic      done;          // One cycle at end of conversion
    dac_code_t dac_code;      // Trial code toward the DAC
    logic      sample;        // Sample hold pulse
    dac_code_t result;        // Last finished conversion
  } sar_status_t;

  typedef struct packed {
    dac_code_t dac_code;
    logic      sample_trg;
    logic      adc_dac_sel;
  } ana_drive_t;

  typedef enum logic [2:0] {
    SAR_IDLE,
    SAR_SAMPLE,
    SAR_SETTLE,
    SAR_COMPARE,
    SAR_DONE
  } sar_state_t;

endpackage

// File: source/sar_adc_reg_file.sv
// Register bus slave for the SAR ADC controller, holding the channel and timing registers
`timescale 1ns/10ps

module sar_adc_reg_file #(
  parameter int NUM_CH = 4
) (
  input  logic                                  mclk,
  input  logic                                  h_reset_n,

  // Register bus
  input  logic                                  reg_cs,
  input  logic                                  reg_wr,
  input  sar_adc_pkg::reg_addr_t                reg_addr,
  input  sar_adc_pkg::reg_data_t                reg_wdata,
  input  sar_adc_pkg::reg_be_t                  reg_be,
  output sar_adc_pkg::reg_data_t                reg_rdata,
  output logic                                  reg_ack,

  // Analog and engine side
  input  logic [NUM_CH-1:0]                     adc_result,  // Raw comparators
  input  sar_adc_pkg::sar_status_t [NUM_CH-1:0] status,
  output sar_adc_pkg::ch_cfg_t [NUM_CH-1:0]     ch_cfg,
  output sar_adc_pkg::sar_timing_t              timing,
  output logic [NUM_CH-1:0]                     cmp_bit      // After inversion
);

  import sar_adc_pkg::*;

  logic      wr_go;     // Write accepted this cycle
  logic      tm_sel;
  reg_data_t rd_word;   // Read mux output

  // ------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------
  assign wr_go  = reg_cs & reg_wr & ~reg_ack;  // Once per access
  assign tm_sel = (reg_addr == TIMING_ADDR);

  // Comparator conditioning shared by all channels
  assign cmp_bit = adc_result ^ {NUM_CH{timing.invert_cmp}};

  // ------------------------------------------------------------
  // Channel registers
  // ------------------------------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      ch_cfg <= '0;
    end else begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        // Lane 0 carries the mode bits
        if (wr_go && reg_addr == reg_addr_t'(ch) && reg_be[0]) begin
          ch_cfg[ch].adc_dac_sel <= reg_wdata[CH_DAC_SEL_BIT];
          ch_cfg[ch].sar_enable  <= reg_wdata[CH_SAR_EN_BIT];
          ch_cfg[ch].man_sample  <= reg_wdata[CH_MAN_TRG_BIT];
        end
        if (wr_go && reg_addr == reg_addr_t'(ch) && reg_be[1]) begin
          ch_cfg[ch].man_dac_code <= reg_wdata[CH_MAN_CODE_LSB +: SAR_BITS];  // Lane 1
        end
        // Done from the engine beats a software set
        if (status[ch].done) begin
          ch_cfg[ch].sample_req <= 1'b0;
        end else if (wr_go && reg_addr == reg_addr_t'(ch) && reg_be[3]) begin
          ch_cfg[ch].sample_req <= reg_wdata[CH_REQ_BIT];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Timing register
  // ------------------------------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      timing <= '0;
    end else if (wr_go && tm_sel) begin
      if (reg_be[0]) begin
        timing.sh_timer  <= reg_wdata[TM_SH_LSB +: 4];
        timing.dac_timer <= reg_wdata[TM_DAC_LSB +: 4];
      end
      if (reg_be[1]) begin
        timing.comp_timer <= reg_wdata[TM_CMP_LSB +: 4];
        timing.invert_cmp <= reg_wdata[TM_INV_BIT];
      end
    end
  end

  // ------------------------------------------------------------
  // Read path
  // ------------------------------------------------------------
  always_comb begin
    rd_word = '0;  // Unmapped reads zero
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (reg_addr == reg_addr_t'(ch)) begin
        rd_word[CH_DAC_SEL_BIT]               = ch_cfg[ch].adc_dac_sel;
        rd_word[CH_SAR_EN_BIT]                = ch_cfg[ch].sar_enable;
        rd_word[CH_MAN_TRG_BIT]               = ch_cfg[ch].man_sample;
        rd_word[CH_MAN_CODE_LSB +: SAR_BITS]  = ch_cfg[ch].man_dac_code;
        rd_word[CH_RESULT_LSB +: SAR_BITS]    = status[ch].result;
        rd_word[CH_CMP_BIT]                   = cmp_bit[ch];  // Live comparator
        rd_word[CH_REQ_BIT]                   = ch_cfg[ch].sample_req;
      end
    end
    if (tm_sel) begin
      rd_word[TM_SH_LSB +: 4]  = timing.sh_timer;
      rd_word[TM_DAC_LSB +: 4] = timing.dac_timer;
      rd_word[TM_CMP_LSB +: 4] = timing.comp_timer;
      rd_word[TM_INV_BIT]      = timing.invert_cmp;
    end
  end

  // Ack one cycle after cs, data valid with it
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      reg_rdata <= '0;
      reg_ack   <= 1'b0;
    end else if (reg_cs && !reg_ack) begin
      reg_rdata <= rd_word;
      reg_ack   <= 1'b1;
    end else begin
      reg_ack   <= 1'b0;
    end
  end

  // Held cs must still see a gap between acks
  ack_single_cycle: assert property (
    @(posedge mclk) disable iff (!h_reset_n) reg_ack |=> !reg_ack
  );

endmodule

// File: source/sar_engine.sv
// Per-channel successive approximation engine, runs one 8-bit search per sample request
`timescale 1ns/10ps

module sar_engine (
  input  logic                     mclk,
  input  logic                     h_reset_n,
  input  sar_adc_pkg::ch_cfg_t     cfg,
  input  sar_adc_pkg::sar_timing_t timing,
  input  logic                     cmp_bit,   // 1 keeps the trial bit
  output sar_adc_pkg::sar_status_t status
);

  import sar_adc_pkg::*;

  localparam int PTR_W = $clog2(SAR_BITS);

  sar_state_t       state_q;
  sar_timer_t       cnt_q;      // Phase down-counter
  logic [PTR_W-1:0] bit_ptr_q;  // Bit under trial
  dac_code_t        code_q;     // Trial code
  dac_code_t        result_q;   // Held until next conversion

  // ------------------------------------------------------------
  // Conversion FSM
  // ------------------------------------------------------------
  // Settle plus compare time must cover the drive register and
  // the external comparator path
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      state_q   <= SAR_IDLE;
      cnt_q     <= '0;
      bit_ptr_q <= '0;
      code_q    <= '0;
      result_q  <= '0;
    end else if (!cfg.sar_enable) begin
      state_q <= SAR_IDLE;  // Abort
    end else begin
      unique case (state_q)
        SAR_IDLE: begin
          if (cfg.sample_req) begin
            state_q   <= SAR_SAMPLE;
            cnt_q     <= timing.sh_timer;
            bit_ptr_q <= PTR_W'(SAR_BITS - 1);  // Start at MSB
            code_q    <= '0;
          end
        end

        SAR_SAMPLE: begin
          if (cnt_q == '0) begin
            state_q           <= SAR_SETTLE;
            cnt_q             <= timing.dac_timer;
            code_q[bit_ptr_q] <= 1'b1;          // First trial bit
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end

        SAR_SETTLE: begin
          if (cnt_q == '0) begin
            state_q <= SAR_COMPARE;
            cnt_q   <= timing.comp_timer;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end

        SAR_COMPARE: begin
          if (cnt_q == '0) begin
            code_q[bit_ptr_q] <= cmp_bit;       // Keep or drop
            if (bit_ptr_q == '0) begin
              state_q <= SAR_DONE;
            end else begin
              state_q                  <= SAR_SETTLE;
              cnt_q                    <= timing.dac_timer;
              bit_ptr_q                <= bit_ptr_q - 1'b1;
              code_q[bit_ptr_q - 1'b1] <= 1'b1; // Next trial
            end
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end

        SAR_DONE: begin
          result_q <= code_q;
          state_q  <= SAR_IDLE;
        end

        default: state_q <= SAR_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Status toward register file and drive selector
  // ------------------------------------------------------------
  assign status.done     = (state_q == SAR_DONE);    // Clears sample_req
  assign status.dac_code = code_q;
  assign status.sample   = (state_q == SAR_SAMPLE);  // sh_timer+1 cycles
  assign status.result   = result_q;

  // Request is gone by the time the FSM is back in idle
  done_one_cycle: assert property (
    @(posedge mclk) disable iff (!h_reset_n)
    status.done |-> (state_q == SAR_DONE) ##1 (!status.done && !cfg.sample_req)
  );

endmodule

// File: source/analog_drive_sel.sv
// Picks manual or SAR drive per channel and registers it toward the analog macros
`timescale 1ns/10ps

module analog_drive_sel #(
  parameter int NUM_CH = 4
) (
  input  logic                                  mclk,
  input  logic                                  h_reset_n,
  input  sar_adc_pkg::ch_cfg_t [NUM_CH-1:0]     ch_cfg,
  input  sar_adc_pkg::sar_status_t [NUM_CH-1:0] status,
  output sar_adc_pkg::ana_drive_t [NUM_CH-1:0]  drive
);

  import sar_adc_pkg::*;

  // Output flops keep DAC and trigger levels clean
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      drive <= '0;
    end else begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (ch_cfg[ch].sar_enable) begin  // Engine owns the channel
          drive[ch].dac_code   <= status[ch].dac_code;
          drive[ch].sample_trg <= status[ch].sample;
        end else begin                     // Software drive
          drive[ch].dac_code   <= ch_cfg[ch].man_dac_code;
          drive[ch].sample_trg <= ch_cfg[ch].man_sample;
        end
        drive[ch].adc_dac_sel <= ch_cfg[ch].adc_dac_sel;
      end
    end
  end

  // ------------------------------------------------------------
  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_chk
    // Trigger is the engine pulse delayed one clock
    sar_trg_follows: assert property (
      @(posedge mclk) disable iff (!h_reset_n)
      ch_cfg[ch].sar_enable |=> (drive[ch].sample_trg == $past(status[ch].sample))
    );
  end

endmodule

// File: source/sar_adc_ctrl.sv
// Top of the SAR ADC controller, joins register file, per-channel engines and output drive
`timescale 1ns/10ps

module sar_adc_ctrl #(
  parameter int NUM_CH = 4
) (
  input  logic                                 mclk,
  input  logic                                 h_reset_n,

  // Register bus
  input  logic                                 reg_cs,
  input  logic                                 reg_wr,
  input  sar_adc_pkg::reg_addr_t               reg_addr,
  input  sar_adc_pkg::reg_data_t               reg_wdata,
  input  sar_adc_pkg::reg_be_t                 reg_be,
  output sar_adc_pkg::reg_data_t               reg_rdata,
  output logic                                 reg_ack,

  // Analog side
  output sar_adc_pkg::dac_code_t [NUM_CH-1:0]  dac_mux_sel,
  output logic [NUM_CH-1:0]                    adc_sample_trg,
  output logic [NUM_CH-1:0]                    adc_dac_sel,
  input  logic [NUM_CH-1:0]                    adc_result     // Comparator outputs
);

  import sar_adc_pkg::*;

  ch_cfg_t [NUM_CH-1:0]     ch_cfg;
  sar_timing_t              timing;     // Shared by all engines
  logic [NUM_CH-1:0]        cmp_bit;
  sar_status_t [NUM_CH-1:0] status;
  ana_drive_t [NUM_CH-1:0]  drive;

  // ------------------------------------------------------------
  sar_adc_reg_file #(
    .NUM_CH (NUM_CH)
  ) u_reg_file (
    .mclk       (mclk),
    .h_reset_n  (h_reset_n),
    .reg_cs     (reg_cs),
    .reg_wr     (reg_wr),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_be     (reg_be),
    .reg_rdata  (reg_rdata),
    .reg_ack    (reg_ack),
    .adc_result (adc_result),
    .status     (status),
    .ch_cfg     (ch_cfg),
    .timing     (timing),
    .cmp_bit    (cmp_bit)
  );

  // One engine per channel
  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_eng
    sar_engine u_sar (
      .mclk      (mclk),
      .h_reset_n (h_reset_n),
      .cfg       (ch_cfg[ch]),
      .timing    (timing),
      .cmp_bit   (cmp_bit[ch]),
      .status    (status[ch])
    );
  end

  analog_drive_sel #(
    .NUM_CH (NUM_CH)
  ) u_drive_sel (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .ch_cfg    (ch_cfg),
    .status    (status),
    .drive     (drive)
  );

  // ------------------------------------------------------------
  // Flatten drive structs onto the analog pins
  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_out
    assign dac_mux_sel[ch]    = drive[ch].dac_code;
    assign adc_sample_trg[ch] = drive[ch].sample_trg;
    assign adc_dac_sel[ch]    = drive[ch].adc_dac_sel;
  end

endmodule

// File: include/tb_sar_cases.svh
// SAR conversion cases, included in the testbench module body after the package import
// Columns: channel, analog value, sh/dac/comp timers, comparator inversion, expected result

typedef struct packed {
  logic [1:0] ch;
  dac_code_t  analog;
  sar_timer_t sh;
  sar_timer_t dac;
  sar_timer_t cmp;
  logic       inv;      // Comparator output inverted
  dac_code_t  exp_res;
} sar_case_t;

localparam int NUM_CASES = 8;
localparam int RAND_ROW  = 3;  // Analog value drawn at run time

// dac plus comp timer of one or more so the trial code reaches the comparator
sar_case_t case_tab [NUM_CASES] = '{
  '{2'd0, 8'd0,   4'd0, 4'd1, 4'd0, 1'b0, 8'd0},
  '{2'd1, 8'd255, 4'd1, 4'd0, 4'd1, 1'b0, 8'd255},
  '{2'd2, 8'd128, 4'd2, 4'd1, 4'd1, 1'b0, 8'd128},
  '{2'd3, 8'd0,   4'd0, 4'd2, 4'd0, 1'b0, 8'd0},    // Random row
  '{2'd0, 8'd77,  4'd3, 4'd0, 4'd2, 1'b1, 8'd77},   // Inverted from here on
  '{2'd1, 8'd0,   4'd0, 4'd1, 4'd1, 1'b1, 8'd0},
  '{2'd2, 8'd255, 4'd1, 4'd1, 4'd0, 1'b1, 8'd255},
  '{2'd3, 8'd128, 4'd0, 4'd0, 4'd3, 1'b1, 8'd128}
};

// File: bench/tb_sar_adc_ctrl.sv
// Testbench for sar_adc_ctrl, runs register, manual drive and SAR conversion checks
`timescale 1ns/10ps

module tb_sar_adc_ctrl;

  import sar_adc_pkg::*;

  localparam int NUM_CH     = 4;
  localparam int BUS_LIMIT  = 8;    // Cycles to wait for ack
  localparam int POLL_LIMIT = 100;  // Status reads per conversion

  logic                     mclk;
  logic                     h_reset_n;
  logic                     reg_cs;
  logic                     reg_wr;
  reg_addr_t                reg_addr;
  reg_data_t                reg_wdata;
  reg_be_t                  reg_be;
  reg_data_t                reg_rdata;
  logic                     reg_ack;
  dac_code_t [NUM_CH-1:0]   dac_mux_sel;
  logic [NUM_CH-1:0]        adc_sample_trg;
  logic [NUM_CH-1:0]        adc_dac_sel;
  logic [NUM_CH-1:0]        adc_result;

  dac_code_t ana_val [NUM_CH];  // Analog input per channel
  logic      inv_model;         // Comparator output inverted
  logic      cmp_on;            // Front end powered
  integer    seed;
  int        n_checks;
  int        n_errors;

  `include "tb_sar_cases.svh"

  sar_adc_ctrl #(
    .NUM_CH (NUM_CH)
  ) DUT (
    .mclk           (mclk),
    .h_reset_n      (h_reset_n),
    .reg_cs         (reg_cs),
    .reg_wr         (reg_wr),
    .reg_addr       (reg_addr),
    .reg_wdata      (reg_wdata),
    .reg_be         (reg_be),
    .reg_rdata      (reg_rdata),
    .reg_ack        (reg_ack),
    .dac_mux_sel    (dac_mux_sel),
    .adc_sample_trg (adc_sample_trg),
    .adc_dac_sel    (adc_dac_sel),
    .adc_result     (adc_result)
  );

  always #50 mclk = ~mclk;  // 100 ns period

  // ------------------------------------------------------------
  // Comparator model, one clock behind the DAC pins
  always @(posedge mclk) begin
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (cmp_on) begin
        adc_result[ch] <= (ana_val[ch] >= dac_mux_sel[ch]) ^ inv_model;
      end else begin
        adc_result[ch] <= 1'b0;  // Powered down
      end
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      $display("ERR %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  // ------------------------------------------------------------
  // Bus access, cs held until ack
  task automatic wait_for_ack(input string what);
    int n;
    n = 0;
    do begin
      @(negedge mclk);
      n++;
    end while (!reg_ack && n < BUS_LIMIT);
    if (!reg_ack) begin
      n_errors++;
      $display("No ack within %0d cycles on %s", BUS_LIMIT, what);
    end
  endtask

  task automatic bus_write(input reg_addr_t addr, input reg_data_t data, input reg_be_t be);
    @(posedge mclk);
    reg_cs    <= 1'b1;
    reg_wr    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    reg_be    <= be;
    wait_for_ack($sformatf("write to address %0d", addr));
    @(posedge mclk);
    reg_cs <= 1'b0;  // Release on the ack edge
    reg_wr <= 1'b0;
  endtask

  task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
    @(posedge mclk);
    reg_cs   <= 1'b1;
    reg_wr   <= 1'b0;
    reg_addr <= addr;
    reg_be   <= '0;
    wait_for_ack($sformatf("read of address %0d", addr));
    data = reg_rdata;  // Valid with ack
    @(posedge mclk);
    reg_cs <= 1'b0;
  endtask

  // Sample request bit drops when the engine is done
  task automatic wait_conv_done(input reg_addr_t addr, output reg_data_t data);
    int polls;
    polls = 0;
    bus_read(addr, data);
    while (data[CH_REQ_BIT] && polls < POLL_LIMIT) begin
      bus_read(addr, data);
      polls++;
    end
    if (data[CH_REQ_BIT]) begin
      n_errors++;
      $display("Conversion on channel %0d did not finish in time", addr);
    end
  endtask

  // ------------------------------------------------------------
  initial begin
    sar_case_t              row;
    reg_data_t              rd;
    reg_data_t              tm;
    reg_data_t              snap [5];
    dac_code_t [NUM_CH-1:0] dac_snap;
    logic [NUM_CH-1:0]      trg_snap;
    int                     n;
    mclk = 1'b0;
    h_reset_n = 1'b0;
    reg_cs = 1'b0;
    reg_wr = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    reg_be = '0;
    adc_result = '0;
    inv_model = 1'b0;
    cmp_on = 1'b0;
    n_checks = 0;
    n_errors = 0;
    for (int c = 0; c < NUM_CH; c++) ana_val[c] = '0;
    seed = 32'he34d;
    case_tab[RAND_ROW].analog  = dac_code_t'($random(seed));
    case_tab[RAND_ROW].exp_res = case_tab[RAND_ROW].analog;  // Search lands on the input
    repeat (3) @(posedge mclk);
    h_reset_n <= 1'b1;

    // Everything idle after reset
    for (int a = 0; a <= int'(TIMING_ADDR); a++) begin
      bus_read(reg_addr_t'(a), rd);
      check_val($sformatf("reset reg %0d", a), 32'h0, rd);
    end
    check_val("reset sample_trg", 32'h0, 32'(adc_sample_trg));
    check_val("reset dac_sel", 32'h0, 32'(adc_dac_sel));

    // Byte lanes on channel 1, junk in the disabled lanes
    bus_write(4'd1, 32'hFFFF_5AFF, 4'b0010);
    bus_read(4'd1, rd);
    check_val("lane 1 only", 32'h0000_5A00, rd);
    bus_write(4'd1, 32'hFFFF_A505, 4'b0001);
    bus_read(4'd1, rd);
    check_val("lane 0 merge", 32'h0000_5A05, rd);
    bus_write(4'd1, 32'hFFFF_FFFF, 4'b0100);  // No field in lane 2
    bus_read(4'd1, rd);
    check_val("lane 2 ignored", 32'h0000_5A05, rd);
    bus_write(TIMING_ADDR, 32'hFFFF_1A37, 4'b0011);
    bus_read(TIMING_ADDR, rd);
    check_val("timing readback", 32'h0000_1A37, rd);
    bus_write(TIMING_ADDR, 32'h0, 4'b0011);
    bus_read(TIMING_ADDR, rd);
    check_val("timing cleared", 32'h0, rd);

    // Manual drive on channel 2
    dac_snap = dac_mux_sel;
    trg_snap = adc_sample_trg;
    bus_write(4'd2, 32'h0000_C305, 4'b0011);
    n = 0;
    do begin
      @(negedge mclk);
      n++;
    end while ((dac_mux_sel[2] !== 8'hC3 || adc_sample_trg[2] !== 1'b1) && n < 2);
    check_val("manual dac code", 32'h0000_00C3, 32'(dac_mux_sel[2]));
    check_val("manual trigger", 32'h1, 32'(adc_sample_trg[2]));
    check_val("manual dac_sel", 32'h1, 32'(adc_dac_sel[2]));
    for (int c = 0; c < NUM_CH; c++) begin
      if (c != 2) begin
        check_val($sformatf("ch%0d dac kept", c), 32'(dac_snap[c]), 32'(dac_mux_sel[c]));
        check_val($sformatf("ch%0d trg kept", c), 32'(trg_snap[c]), 32'(adc_sample_trg[c]));
      end
    end

    // Unmapped address 7
    for (int a = 0; a < 5; a++) bus_read(reg_addr_t'(a), snap[a]);
    bus_write(4'd7, 32'hFFFF_FFFF, 4'hF);
    bus_read(4'd7, rd);
    check_val("unmapped read", 32'h0, rd);
    for (int a = 0; a < 5; a++) begin
      bus_read(reg_addr_t'(a), rd);
      check_val($sformatf("reg %0d after unmapped write", a), snap[a], rd);
    end

    // ------------------------------------------------------------
    // SAR conversions from the case table
    @(posedge mclk);
    cmp_on <= 1'b1;
    for (int i = 0; i < NUM_CASES; i++) begin
      row = case_tab[i];
      @(posedge mclk);
      ana_val[row.ch] <= row.analog;
      inv_model       <= row.inv;
      tm = '0;
      tm[TM_SH_LSB +: 4]  = row.sh;
      tm[TM_DAC_LSB +: 4] = row.dac;
      tm[TM_CMP_LSB +: 4] = row.cmp;
      tm[TM_INV_BIT]      = row.inv;
      bus_write(TIMING_ADDR, tm, 4'b0011);
      bus_write(reg_addr_t'(row.ch), 32'h8000_0002, 4'b1001);  // sar_enable and request
      wait_conv_done(reg_addr_t'(row.ch), rd);
      bus_read(reg_addr_t'(row.ch), rd);
      check_val($sformatf("row %0d result", i), 32'(row.exp_res),
                32'(rd[CH_RESULT_LSB +: SAR_BITS]));
      // DAC parked on the result, so the undone comparator reads input >= code
      check_val($sformatf("row %0d cmp bit", i), 32'(row.analog >= row.exp_res),
                32'(rd[CH_CMP_BIT]));
    end

    $display("Checks: %0d  errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+include
source/sar_adc_pkg.sv
source/sar_adc_reg_file.sv
source/sar_engine.sv
source/analog_drive_sel.sv
source/sar_adc_ctrl.sv
bench/tb_sar_adc_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SAR ADC controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_sar_adc_ctrl -Mdir obj_dir
out=$(./obj_dir/Vtb_sar_adc_ctrl)
echo "$out"
if echo "$out" | grep -qxF '>>> PASS'; then
  exit 0
else
  exit 1
fi
